// ==== logic/acq_pkg.sv ====
/*
  shared types and constants for the acquisition core
  wishbone addresses are word addresses, 4 bits wide
  pin word fields must add up to OUT_W, leds at bit 0
*/
package acq_pkg;

  ////////////////////////////////////////
  // register and counter widths

  localparam int DATA_W     = 32;   // wishbone data, register width
  localparam int CNT_W      = 24;   // precharge clock count
  localparam int MODE_W     = 3;    // control register mode field
  localparam int SEQ_N_W    = 3;    // sequence length field
  localparam int IDX_W      = 3;    // sample index, matches seq_n range
  localparam int HW_FLAGS_W = 4;

  ////////////////////////////////////////
  // pin word fields, lsb first

  localparam int LEDS_W  = 4;
  localparam int MON_W   = 8;
  localparam int PCSW_W  = 2;
  localparam int AZMUX_W = 4;

  localparam int ENTRY_W = AZMUX_W + PCSW_W;                   // azmux low, pc_sw high
  localparam int OUT_W   = LEDS_W + MON_W + PCSW_W + AZMUX_W + 1; // + meas_complete

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

  // operating modes. codes not listed drive all pins low
  typedef enum logic [MODE_W-1:0] {
    MODE_DIRECT   = 3'd0,
    MODE_SEQ_MOCK = 3'd6
  } acq_mode_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_PRECHARGE,
    SEQ_ACQUIRE
  } seq_state_e;

  typedef enum logic [3:0] {
    REG_CR        = 4'd0,
    REG_DIRECT    = 4'd1,
    REG_STATUS    = 4'd2,   // read only
    REG_PRECHARGE = 4'd3,
    REG_APERTURE  = 4'd4,
    REG_SEQ_N     = 4'd5,
    REG_SEQ0      = 4'd6,
    REG_SEQ1      = 4'd7,
    REG_SEQ2      = 4'd8,
    REG_SEQ3      = 4'd9
  } reg_addr_e;

endpackage

// ==== logic/wb_reg_file.sv ====
/*
  wishbone classic slave, one ack per request, no wait states beyond one cycle
  master must hold cyc/stb until ack. writes land on the ack edge
  fields are stored at their own width and read back zero-extended
  seq entries occupy REG_SEQ0 upward, SEQ_DEPTH words. unmapped reads give 0
*/
module wb_reg_file #(
  parameter int SEQ_DEPTH = 4
) (
  input  logic                                        CLK,
  input  logic                                        rst_i,

  input  logic                                        wb_cyc_i,
  input  logic                                        wb_stb_i,
  input  logic                                        wb_we_i,
  input  acq_pkg::reg_addr_e                          wb_adr_i,
  input  logic [acq_pkg::DATA_W-1:0]                  wb_dat_i,
  output logic                                        wb_ack_o,
  output logic [acq_pkg::DATA_W-1:0]                  wb_dat_o,

  input  logic [acq_pkg::HW_FLAGS_W-1:0]              hw_flags_i,
  input  logic [acq_pkg::IDX_W-1:0]                   sample_idx_last_i,
  input  logic                                        first_last_i,

  output acq_pkg::acq_mode_e                          mode_o,
  output logic [acq_pkg::OUT_W-1:0]                   direct_o,
  output logic [acq_pkg::CNT_W-1:0]                   precharge_o,
  output logic [acq_pkg::DATA_W-1:0]                  aperture_o,
  output logic [acq_pkg::SEQ_N_W-1:0]                 seq_n_o,
  output logic [SEQ_DEPTH-1:0][acq_pkg::ENTRY_W-1:0]  seq_entries_o
);
  import acq_pkg::*;

  localparam int SEL_W = (SEQ_DEPTH > 1) ? $clog2(SEQ_DEPTH) : 1;

  acq_mode_e                          mode_q;
  logic [OUT_W-1:0]                   direct_q;
  logic [CNT_W-1:0]                   precharge_q;
  logic [DATA_W-1:0]                  aperture_q;
  logic [SEQ_N_W-1:0]                 seq_n_q;
  logic [SEQ_DEPTH-1:0][ENTRY_W-1:0]  entries_q;

  logic                               ack_q;
  logic                               req;
  logic                               wr_en;
  logic [3:0]                         seq_off;
  logic                               seq_sel;
  logic [SEL_W-1:0]                   seq_idx;
  logic [DATA_W-1:0]                  status_word;
  logic [DATA_W-1:0]                  rd_data;

  assign req   = wb_cyc_i & wb_stb_i & ~ack_q;   // new request, not the one being acked
  assign wr_en = req & wb_we_i;

  // seq entry window
  assign seq_off = 4'(wb_adr_i - REG_SEQ0);
  assign seq_sel = (wb_adr_i >= REG_SEQ0) && (seq_off < SEQ_DEPTH);
  assign seq_idx = seq_off[SEL_W-1:0];

  ////////////////////////////////////////
  // status word

  assign status_word = {
    {(DATA_W-23){1'b0}},
    seq_n_q,                          // 22..20
    first_last_i,                     // 19
    sample_idx_last_i,                // 18..16
    {(8-HW_FLAGS_W){1'b0}},           // 15..12
    hw_flags_i,                       // 11..8
    STATUS_MAGIC                      // 7..0
  };

  ////////////////////////////////////////
  // write side and ack

  always_ff @(posedge CLK)
  begin
    if (rst_i)
    begin
      ack_q       <= 1'b0;
      mode_q      <= MODE_DIRECT;     // pins follow direct word, all zero
      direct_q    <= '0;
      precharge_q <= '0;
      aperture_q  <= '0;
      seq_n_q     <= '0;
      entries_q   <= '0;
    end
    else
    begin
      ack_q <= req;
      if (wr_en)
      begin
        case (wb_adr_i)
          REG_CR:        mode_q      <= acq_mode_e'(wb_dat_i[MODE_W-1:0]);
          REG_DIRECT:    direct_q    <= wb_dat_i[OUT_W-1:0];
          REG_PRECHARGE: precharge_q <= wb_dat_i[CNT_W-1:0];
          REG_APERTURE:  aperture_q  <= wb_dat_i;
          REG_SEQ_N:     seq_n_q     <= wb_dat_i[SEQ_N_W-1:0];
          default:
          begin
            if (seq_sel)
              entries_q[seq_idx] <= wb_dat_i[ENTRY_W-1:0];   // status and holes ignored
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // read side, address still held during ack

  always_comb
  begin
    rd_data = '0;
    case (wb_adr_i)
      REG_CR:        rd_data = DATA_W'(mode_q);
      REG_DIRECT:    rd_data = DATA_W'(direct_q);
      REG_STATUS:    rd_data = status_word;
      REG_PRECHARGE: rd_data = DATA_W'(precharge_q);
      REG_APERTURE:  rd_data = aperture_q;
      REG_SEQ_N:     rd_data = DATA_W'(seq_n_q);
      default:
      begin
        if (seq_sel)
          rd_data = DATA_W'(entries_q[seq_idx]);
      end
    endcase
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = ack_q ? rd_data : '0;

  assign mode_o        = mode_q;
  assign direct_o      = direct_q;
  assign precharge_o   = precharge_q;
  assign aperture_o    = aperture_q;
  assign seq_n_o       = seq_n_q;
  assign seq_entries_o = entries_q;

  // held strobe must not be acked twice in a row
  assert property (@(posedge CLK) disable iff (rst_i)
    (wb_ack_o && wb_stb_i) |=> !wb_ack_o);

endmodule

// ==== logic/seq_acquisition.sv ====
/*
  sequence controller, precharge then acquire for each entry
  held idle while trig_i is low. precharge count 0 behaves as 1
  index wraps at seq_n, clamped to SEQ_DEPTH. seq_n of 0 repeats entry 0
*/
module seq_acquisition #(
  parameter int SEQ_DEPTH = 4
) (
  input  logic                                        CLK,
  input  logic                                        rst_i,
  input  logic                                        trig_i,
  input  logic                                        measure_valid_i,
  input  logic [acq_pkg::CNT_W-1:0]                   precharge_i,
  input  logic [acq_pkg::SEQ_N_W-1:0]                 seq_n_i,
  input  logic [SEQ_DEPTH-1:0][acq_pkg::ENTRY_W-1:0]  seq_entries_i,

  output logic [acq_pkg::AZMUX_W-1:0]                 azmux_o,
  output logic [acq_pkg::PCSW_W-1:0]                  pc_sw_o,
  output logic                                        adc_run_o,
  output logic [acq_pkg::LEDS_W-1:0]                  leds_o,
  output logic [acq_pkg::MON_W-1:0]                   monitor_o,
  output logic [acq_pkg::IDX_W-1:0]                   sample_idx_last_o,
  output logic                                        first_last_o
);
  import acq_pkg::*;

  localparam int SEL_W = (SEQ_DEPTH > 1) ? $clog2(SEQ_DEPTH) : 1;

  seq_state_e          state_q;
  logic [IDX_W-1:0]    idx_q;
  logic [CNT_W-1:0]    pc_cnt_q;
  logic [IDX_W-1:0]    idx_last_q;
  logic                first_last_q;

  logic                hold;
  logic                active;
  logic                sample_done;
  logic [CNT_W-1:0]    pc_load;
  logic [IDX_W:0]      seq_lim;
  logic [IDX_W:0]      idx_inc;
  logic [IDX_W-1:0]    idx_next;
  logic [ENTRY_W-1:0]  entry;

  assign hold        = rst_i | ~trig_i;
  assign active      = (state_q != SEQ_IDLE);
  assign sample_done = ~hold & (state_q == SEQ_ACQUIRE) & measure_valid_i;

  // down-counter reload, P cycles of precharge
  assign pc_load = (precharge_i == '0) ? '0 : precharge_i - 1'b1;

  ////////////////////////////////////////
  // index wrap

  always_comb
  begin
    if (seq_n_i == '0)
      seq_lim = (IDX_W+1)'(1);
    else if (seq_n_i > SEQ_DEPTH)
      seq_lim = (IDX_W+1)'(SEQ_DEPTH);
    else
      seq_lim = {1'b0, seq_n_i};
  end

  assign idx_inc  = {1'b0, idx_q} + (IDX_W+1)'(1);
  assign idx_next = (idx_inc >= seq_lim) ? '0 : idx_inc[IDX_W-1:0];

  assign entry = seq_entries_i[idx_q[SEL_W-1:0]];   // idx always below SEQ_DEPTH

  ////////////////////////////////////////
  // fsm

  always_ff @(posedge CLK)
  begin
    if (hold)
    begin
      state_q  <= SEQ_IDLE;
      idx_q    <= '0;
      pc_cnt_q <= '0;
    end
    else
    begin
      case (state_q)
        SEQ_IDLE:
        begin
          state_q  <= SEQ_PRECHARGE;   // start at entry 0
          idx_q    <= '0;
          pc_cnt_q <= pc_load;
        end
        SEQ_PRECHARGE:
        begin
          if (pc_cnt_q == '0)
            state_q <= SEQ_ACQUIRE;
          else
            pc_cnt_q <= pc_cnt_q - 1'b1;
        end
        SEQ_ACQUIRE:
        begin
          if (sample_done)
          begin
            state_q  <= SEQ_PRECHARGE;
            idx_q    <= idx_next;
            pc_cnt_q <= pc_load;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // last completed sample, kept across trig drops
  always_ff @(posedge CLK)
  begin
    if (rst_i)
    begin
      idx_last_q   <= '0;
      first_last_q <= 1'b0;
    end
    else if (sample_done)
    begin
      idx_last_q   <= idx_q;
      first_last_q <= (idx_q == '0);   // sample was entry 0
    end
  end

  assign azmux_o   = active ? entry[AZMUX_W-1:0] : '0;
  assign pc_sw_o   = active ? entry[ENTRY_W-1:AZMUX_W] : '0;
  assign adc_run_o = (state_q == SEQ_ACQUIRE);

  assign leds_o    = LEDS_W'(1) << idx_q;   // one-hot index
  assign monitor_o = {1'b0, state_q, idx_q, measure_valid_i, adc_run_o};

  assign sample_idx_last_o = idx_last_q;
  assign first_last_o      = first_last_q;

  // adc mock only answers while acquiring
  assert property (@(posedge CLK) disable iff (rst_i)
    (trig_i && measure_valid_i) |-> (state_q == SEQ_ACQUIRE));

endmodule

// ==== logic/adc_mock.sv ====
/*
  stand-in for the adc. counts aperture cycles while run_i is high
  measure_valid_o pulses once, A+1 cycles after run rises
  re-arms only after run_i falls
*/
module adc_mock (
  input  logic                        CLK,
  input  logic                        rst_i,
  input  logic                        run_i,
  input  logic [acq_pkg::DATA_W-1:0]  aperture_i,
  output logic                        measure_valid_o
);
  import acq_pkg::*;

  logic [DATA_W-1:0]  cnt_q;
  logic               fired_q;    // pulse sent, waiting for run to drop
  logic               valid_q;

  always_ff @(posedge CLK)
  begin
    if (rst_i || !run_i)
    begin
      cnt_q   <= '0;
      fired_q <= 1'b0;
      valid_q <= 1'b0;
    end
    else if (!fired_q)
    begin
      if (cnt_q == aperture_i)
      begin
        valid_q <= 1'b1;          // end of aperture
        fired_q <= 1'b1;
      end
      else
        cnt_q <= cnt_q + 1'b1;
    end
    else
      valid_q <= 1'b0;            // single cycle
  end

  assign measure_valid_o = valid_q;

endmodule

// ==== logic/mode_mux.sv ====
/*
  selects direct word or sequencer signals onto the pins, registered once
  unused mode codes drive all pins low
  pin word, lsb first: leds, monitor, pc_sw, azmux, meas_complete
*/
module mode_mux (
  input  logic                          CLK,
  input  logic                          rst_i,
  input  acq_pkg::acq_mode_e            mode_i,
  input  logic [acq_pkg::OUT_W-1:0]     direct_i,

  input  logic [acq_pkg::LEDS_W-1:0]    seq_leds_i,
  input  logic [acq_pkg::MON_W-1:0]     seq_monitor_i,
  input  logic [acq_pkg::PCSW_W-1:0]    seq_pc_sw_i,
  input  logic [acq_pkg::AZMUX_W-1:0]   seq_azmux_i,
  input  logic                          measure_valid_i,

  output logic [acq_pkg::LEDS_W-1:0]    leds_o,
  output logic [acq_pkg::MON_W-1:0]     monitor_o,
  output logic [acq_pkg::PCSW_W-1:0]    pc_sw_o,
  output logic [acq_pkg::AZMUX_W-1:0]   azmux_o,
  output logic                          meas_complete_o
);
  import acq_pkg::*;

  logic [OUT_W-1:0]  seq_word;
  logic [OUT_W-1:0]  sel_word;
  logic [OUT_W-1:0]  out_q;

  // same layout as the direct register
  assign seq_word = {measure_valid_i, seq_azmux_i, seq_pc_sw_i, seq_monitor_i, seq_leds_i};

  always_comb
  begin
    case (mode_i)
      MODE_DIRECT:   sel_word = direct_i;
      MODE_SEQ_MOCK: sel_word = seq_word;
      default:       sel_word = '0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (rst_i)
      out_q <= '0;
    else
      out_q <= sel_word;
  end

  assign {meas_complete_o, azmux_o, pc_sw_o, monitor_o, leds_o} = out_q;

endmodule

// ==== logic/acq_top.sv ====
/*
  acquisition core top, wishbone register access and mocked adc
  sa_trig_i must be high for the sequencer to run
  SEQ_DEPTH up to 8, limited by the 3 bit index
*/
module acq_top #(
  parameter int SEQ_DEPTH = 4
) (
  input  logic                            CLK,
  input  logic                            rst_i,

  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  acq_pkg::reg_addr_e              wb_adr_i,
  input  logic [acq_pkg::DATA_W-1:0]      wb_dat_i,
  output logic [acq_pkg::DATA_W-1:0]      wb_dat_o,
  output logic                            wb_ack_o,

  input  logic [acq_pkg::HW_FLAGS_W-1:0]  hw_flags_i,
  input  logic                            sa_trig_i,

  output logic [acq_pkg::LEDS_W-1:0]      leds_o,
  output logic [acq_pkg::MON_W-1:0]       monitor_o,
  output logic [acq_pkg::PCSW_W-1:0]      pc_sw_o,
  output logic [acq_pkg::AZMUX_W-1:0]     azmux_o,
  output logic                            meas_complete_o
);
  import acq_pkg::*;

  // register file outputs
  acq_mode_e                          cr_mode;
  logic [OUT_W-1:0]                   reg_direct;
  logic [CNT_W-1:0]                   reg_precharge;
  logic [DATA_W-1:0]                  reg_aperture;
  logic [SEQ_N_W-1:0]                 reg_seq_n;
  logic [SEQ_DEPTH-1:0][ENTRY_W-1:0]  reg_seq_entries;

  // sequencer
  logic [AZMUX_W-1:0]                 sa_azmux;
  logic [PCSW_W-1:0]                  sa_pc_sw;
  logic [LEDS_W-1:0]                  sa_leds;
  logic [MON_W-1:0]                   sa_monitor;
  logic [IDX_W-1:0]                   sa_sample_idx_last;
  logic                               sa_first_last;
  logic                               adc_run;
  logic                               measure_valid;

  wb_reg_file #(
    .SEQ_DEPTH(SEQ_DEPTH)
  ) u_reg_file (
    .CLK               (CLK),
    .rst_i             (rst_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_we_i           (wb_we_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_ack_o          (wb_ack_o),
    .wb_dat_o          (wb_dat_o),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sa_sample_idx_last),   // back from sequencer for status
    .first_last_i      (sa_first_last),
    .mode_o            (cr_mode),
    .direct_o          (reg_direct),
    .precharge_o       (reg_precharge),
    .aperture_o        (reg_aperture),
    .seq_n_o           (reg_seq_n),
    .seq_entries_o     (reg_seq_entries)
  );

  seq_acquisition #(
    .SEQ_DEPTH(SEQ_DEPTH)
  ) u_seq (
    .CLK               (CLK),
    .rst_i             (rst_i),
    .trig_i            (sa_trig_i),
    .measure_valid_i   (measure_valid),
    .precharge_i       (reg_precharge),
    .seq_n_i           (reg_seq_n),
    .seq_entries_i     (reg_seq_entries),
    .azmux_o           (sa_azmux),
    .pc_sw_o           (sa_pc_sw),
    .adc_run_o         (adc_run),
    .leds_o            (sa_leds),
    .monitor_o         (sa_monitor),
    .sample_idx_last_o (sa_sample_idx_last),
    .first_last_o      (sa_first_last)
  );

  adc_mock u_adc_mock (
    .CLK             (CLK),
    .rst_i           (rst_i),
    .run_i           (adc_run),
    .aperture_i      (reg_aperture),
    .measure_valid_o (measure_valid)
  );

  mode_mux u_mode_mux (
    .CLK             (CLK),
    .rst_i           (rst_i),
    .mode_i          (cr_mode),
    .direct_i        (reg_direct),
    .seq_leds_i      (sa_leds),
    .seq_monitor_i   (sa_monitor),
    .seq_pc_sw_i     (sa_pc_sw),
    .seq_azmux_i     (sa_azmux),
    .measure_valid_i (measure_valid),
    .leds_o          (leds_o),
    .monitor_o       (monitor_o),
    .pc_sw_o         (pc_sw_o),
    .azmux_o         (azmux_o),
    .meas_complete_o (meas_complete_o)
  );

endmodule

// ==== tests/tb_acq_top.sv ====
/*
  testbench for acq_top with SEQ_DEPTH 4, wishbone access and mocked sequence runs
  sequence runs use precharge and aperture counts of 1..8 and seq_n of 2..SEQ_DEPTH
  expected values come from a shadow copy of the registers
*/
module tb_acq_top;
  timeunit 1ns;
  timeprecision 100ps;
  import acq_pkg::*;

  localparam int SEQ_DEPTH = 4;
  // about 700 cycles of tests (reg phase ~150, two runs of ~10 samples x <=18 cycles)
  localparam int MAX_CYCLES = 6000;

  logic                   CLK;
  logic                   rst_i;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  reg_addr_e              wb_adr_i;
  logic [DATA_W-1:0]      wb_dat_i;
  logic [DATA_W-1:0]      wb_dat_o;
  logic                   wb_ack_o;
  logic [HW_FLAGS_W-1:0]  hw_flags_i;
  logic                   sa_trig_i;
  logic [LEDS_W-1:0]      leds_o;
  logic [MON_W-1:0]       monitor_o;
  logic [PCSW_W-1:0]      pc_sw_o;
  logic [AZMUX_W-1:0]     azmux_o;
  logic                   meas_complete_o;

  // shadow registers
  logic [MODE_W-1:0]      m_mode;
  logic [OUT_W-1:0]       m_direct;
  logic [CNT_W-1:0]       m_precharge;
  logic [DATA_W-1:0]      m_aperture;
  logic [SEQ_N_W-1:0]     m_seq_n;
  logic [ENTRY_W-1:0]     m_entry [SEQ_DEPTH];
  logic [HW_FLAGS_W-1:0]  m_flags;
  logic [IDX_W-1:0]       m_idx_last;
  logic                   m_first_last;

  // pending compares
  string        chk_name_q[$];
  logic [31:0]  chk_got_q[$];
  logic [31:0]  chk_exp_q[$];
  int           error_count = 0;
  int           cycle_cnt = 0;
  integer       seed = 32;

  acq_top #(
    .SEQ_DEPTH(SEQ_DEPTH)
  ) dut (
    .CLK             (CLK),
    .rst_i           (rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .hw_flags_i      (hw_flags_i),
    .sa_trig_i       (sa_trig_i),
    .leds_o          (leds_o),
    .monitor_o       (monitor_o),
    .pc_sw_o         (pc_sw_o),
    .azmux_o         (azmux_o),
    .meas_complete_o (meas_complete_o)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;   // 10 ns
  end

  // watchdog
  always @(posedge CLK)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES)
    begin
      $display("timeout, test did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped by watchdog");
    end
  end

  ////////////////////////////////////////
  // reference model

  function automatic void store_field(input logic [3:0] addr, input logic [31:0] data);
    case (addr)
      REG_CR:        m_mode      = data[MODE_W-1:0];
      REG_DIRECT:    m_direct    = data[OUT_W-1:0];
      REG_PRECHARGE: m_precharge = data[CNT_W-1:0];
      REG_APERTURE:  m_aperture  = data;
      REG_SEQ_N:     m_seq_n     = data[SEQ_N_W-1:0];
      default:
      begin
        if (addr >= REG_SEQ0 && addr < REG_SEQ0 + SEQ_DEPTH)
          m_entry[addr - REG_SEQ0] = data[ENTRY_W-1:0];   // status, holes dropped
      end
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [3:0] addr);
    logic [31:0] r;
    r = '0;
    case (addr)
      REG_CR:        r = 32'(m_mode);
      REG_DIRECT:    r = 32'(m_direct);
      REG_STATUS:    r = {9'b0, m_seq_n, m_first_last, m_idx_last, 4'b0, m_flags, 8'hAA};
      REG_PRECHARGE: r = 32'(m_precharge);
      REG_APERTURE:  r = m_aperture;
      REG_SEQ_N:     r = 32'(m_seq_n);
      default:
      begin
        if (addr >= REG_SEQ0 && addr < REG_SEQ0 + SEQ_DEPTH)
          r = 32'(m_entry[addr - REG_SEQ0]);
      end
    endcase
    return r;
  endfunction

  // pin word outside seq mode
  function automatic logic [OUT_W-1:0] expected_direct_pins(input logic [MODE_W-1:0] mode,
                                                            input logic [OUT_W-1:0] direct);
    if (mode == MODE_DIRECT)
      return direct;
    else
      return '0;
  endfunction

  // pin word at the meas_complete pulse of sample idx
  function automatic logic [OUT_W-1:0] expected_seq_pins(input int idx);
    logic [ENTRY_W-1:0] ent;
    logic [MON_W-1:0]   mon;
    ent = m_entry[idx];
    mon = {1'b0, 2'(SEQ_ACQUIRE), 3'(idx), 1'b1, 1'b1};   // valid and run both high
    return {1'b1, ent[3:0], ent[5:4], mon, 4'(1 << idx)};
  endfunction

  ////////////////////////////////////////
  // compare process

  always @(posedge CLK)
  begin : compare_proc
    string       name;
    logic [31:0] got;
    logic [31:0] exp;
    while (chk_name_q.size() > 0)
    begin
      name = chk_name_q.pop_front();
      got  = chk_got_q.pop_front();
      exp  = chk_exp_q.pop_front();
      assert (got === exp)
      else
      begin
        error_count++;
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1, "mismatch on %s", name);
      end
    end
  end

  task automatic queue_check(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_name_q.push_back(name);
    chk_got_q.push_back(got);
    chk_exp_q.push_back(exp);
  endtask

  task automatic check_pins(input logic [OUT_W-1:0] exp);
    queue_check("leds_o", 32'(leds_o), 32'(exp[3:0]));
    queue_check("monitor_o", 32'(monitor_o), 32'(exp[11:4]));
    queue_check("pc_sw_o", 32'(pc_sw_o), 32'(exp[13:12]));
    queue_check("azmux_o", 32'(azmux_o), 32'(exp[17:14]));
    queue_check("meas_complete_o", 32'(meas_complete_o), 32'(exp[18]));
  endtask

  ////////////////////////////////////////
  // wishbone master, called 1 ns after an edge

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = reg_addr_e'(addr);
    wb_dat_i = data;
    do
    begin
      @(posedge CLK);
      #1;
    end while (!wb_ack_o);   // hold until ack
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    store_field(addr, data);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = reg_addr_e'(addr);
    do
    begin
      @(posedge CLK);
      #1;
    end while (!wb_ack_o);
    data     = wb_dat_o;     // valid with ack
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // sequence helpers

  task automatic configure_sequence(input int p, input int a, input int n);
    logic [31:0] wd;
    write_reg(REG_PRECHARGE, 32'(p));
    write_reg(REG_APERTURE, 32'(a));
    write_reg(REG_SEQ_N, 32'(n));
    for (int i = 0; i < SEQ_DEPTH; i++)
    begin
      wd = $random(seed);
      write_reg(4'(REG_SEQ0 + i), wd);
    end
    write_reg(REG_CR, 32'(MODE_SEQ_MOCK));
  endtask

  task automatic wait_meas_complete();
    do
    begin
      @(posedge CLK);
      #1;
    end while (!meas_complete_o);
  endtask

  // trig high, then check samples against entry order and period
  task automatic run_sequence(input int samples);
    int          e;
    int          prev_cycle;
    logic [31:0] rd;
    e          = 0;
    prev_cycle = -1;
    sa_trig_i  = 1'b1;
    for (int s = 0; s < samples; s++)
    begin
      wait_meas_complete();
      check_pins(expected_seq_pins(e));
      if (prev_cycle >= 0)
        queue_check("meas_complete_o period", 32'(cycle_cnt - prev_cycle),
                    32'(m_precharge) + m_aperture + 32'd2);
      prev_cycle   = cycle_cnt;
      m_idx_last   = 3'(e);
      m_first_last = (e == 0);
      read_reg(REG_STATUS, rd);   // status already holds this sample
      queue_check("wb_dat_o (status)", rd, expected_read(REG_STATUS));
      e = (e + 1) % m_seq_n;      // wrap at seq_n
    end
  endtask

  task automatic drop_trigger();
    @(posedge CLK);
    #1;
    sa_trig_i = 1'b0;
    repeat (3) @(posedge CLK);   // fsm idle, then mux flushed
    #1;
    repeat (8)
    begin
      queue_check("pc_sw_o", 32'(pc_sw_o), 32'd0);
      queue_check("azmux_o", 32'(azmux_o), 32'd0);
      queue_check("meas_complete_o", 32'(meas_complete_o), 32'd0);
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic drain_checks();
    while (chk_name_q.size() != 0)
      @(posedge CLK);
    @(posedge CLK);
  endtask

  ////////////////////////////////////////
  // stimulus

  initial
  begin : stimulus
    logic [31:0] rd;
    logic [31:0] wd;
    int          p;
    int          a;
    int          n;
    rst_i        = 1'b1;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = REG_CR;
    wb_dat_i     = '0;
    hw_flags_i   = '0;
    sa_trig_i    = 1'b0;
    m_mode       = '0;
    m_direct     = '0;
    m_precharge  = '0;
    m_aperture   = '0;
    m_seq_n      = '0;
    m_flags      = '0;
    m_idx_last   = '0;
    m_first_last = 1'b0;
    for (int i = 0; i < SEQ_DEPTH; i++)
      m_entry[i] = '0;

    repeat (10) @(posedge CLK);
    #1;
    rst_i = 1'b0;

    // reset state
    check_pins('0);
    queue_check("wb_ack_o", 32'(wb_ack_o), 32'd0);

    // readback of every address, unmapped ones give 0
    repeat (2)
    begin
      for (int addr = 0; addr < 16; addr++)
      begin
        wd = $random(seed);
        write_reg(4'(addr), wd);
        read_reg(4'(addr), rd);
        queue_check("wb_dat_o", rd, expected_read(4'(addr)));
      end
    end

    // status with random flags
    repeat (4)
    begin
      m_flags    = 4'($random(seed));
      hw_flags_i = m_flags;
      read_reg(REG_STATUS, rd);
      queue_check("wb_dat_o (status)", rd, expected_read(REG_STATUS));
    end

    // direct mode
    write_reg(REG_CR, 32'(MODE_DIRECT));
    repeat (4)
    begin
      wd = $random(seed);
      write_reg(REG_DIRECT, wd);
      @(posedge CLK);             // one register stage in the mux
      #1;
      check_pins(expected_direct_pins(m_mode, m_direct));
    end

    // unused modes, pins all low
    for (int m = 1; m < 8; m++)
    begin
      if (m != MODE_SEQ_MOCK)
      begin
        write_reg(REG_CR, 32'(m));
        @(posedge CLK);
        #1;
        check_pins(expected_direct_pins(m_mode, m_direct));
      end
    end

    // two sequence runs, second one checks restart at entry 0
    for (int run = 0; run < 2; run++)
    begin
      p = 1 + ({$random(seed)} % 8);
      a = 1 + ({$random(seed)} % 8);
      n = 2 + ({$random(seed)} % (SEQ_DEPTH - 1));
      configure_sequence(p, a, n);
      run_sequence(2 * n + 2);
      drop_trigger();
    end

    drain_checks();
    if (error_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== acq_top.f ====
logic/acq_pkg.sv
logic/wb_reg_file.sv
logic/seq_acquisition.sv
logic/adc_mock.sv
logic/mode_mux.sv
logic/acq_top.sv
tests/tb_acq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the acquisition core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_acq_top \
  -f acq_top.f -o tb_acq_top > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/tb_acq_top > sim.log 2>&1
cat sim.log
grep -q "^STATUS: PASS$" sim.log && exit 0 || exit 1
